// ==== rtl/icache_config.svh ====
// build-time sizes for the icache data array, included by the packages and the top level
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address width of the data RAM, so the array holds 2**AW words
`define ICACHE_DATA_RAM_AW 8

// width of one fetch word as seen on the request and response ports
`define ICACHE_DATA_DW 64

// 1 stores the full 72-bit SECDED codeword
// 0 stores the bare 64 data bits and both error flags stay low
`define ICACHE_ECC_EN 1

`endif

// ==== rtl/ecc_pkg.sv ====
// SECDED codeword, check-bit and status types shared by the ECC encoder, decoder and data array
`include "icache_config.svh"

package ecc_pkg;

	// parity sits in bit 0, hamming check ci in bit i+1
	typedef struct packed {
		logic [6:0] hamming;
		logic       parity;
	} ecc_check_t;

	typedef struct packed {
		ecc_check_t                  check;
		logic [`ICACHE_DATA_DW-1:0]  data;
	} ecc_codeword_t;

	typedef struct packed {
		logic single_err; // corrected or harmless single flip
		logic double_err; // uncorrectable, data returned as stored
	} ecc_status_t;

	// hamming position of data bit idx, skipping the power-of-two check slots
	function automatic logic [6:0] data_pos(input int unsigned idx);
		int unsigned n;
		logic [6:0]  pos;
		n = 0;
		pos = '0;
		for (int unsigned p = 3; p < 72; p++) begin
			if ((p & (p - 1)) != 0) begin
				if (n == idx)
					pos = 7'(p);
				n++;
			end
		end
		return pos;
	endfunction

endpackage

// ==== rtl/icache_pkg.sv ====
// request and response types of the icache data array port, used by the top level and testbench
`include "icache_config.svh"

package icache_pkg;

	// one access per cycle, no handshake
	typedef struct packed {
		logic                                     cs;
		logic                                     we;
		logic [`ICACHE_DATA_RAM_AW-1:0]           addr;
		logic [`ICACHE_DATA_DW-1:0]               wdata;
		logic [$bits(ecc_pkg::ecc_codeword_t)-1:0] inject; // flip mask xor-ed onto the write
	} icache_data_req_t;

	// valid pulses for one cycle, one cycle after a read is sampled
	typedef struct packed {
		logic                       valid;
		logic [`ICACHE_DATA_DW-1:0] rdata;
		ecc_pkg::ecc_status_t       status;
	} icache_data_rsp_t;

endpackage

// ==== rtl/icache_data_ecc_ram.sv ====
// behavioural single-port synchronous RAM standing in for the icache data macros
`timescale 1ns/1ps

module icache_data_ecc_ram #(
	parameter int AW = 8,
	parameter int DW = 72
) (
	input  logic          clk,
	input  logic          cs,
	input  logic          we,
	input  logic [AW-1:0] addr,
	input  logic [DW-1:0] wdata,
	output logic [DW-1:0] rdata
);

	localparam int DEPTH = 2 ** AW;

	logic [DW-1:0] mem [DEPTH];

	// write and read share the one port, cs low keeps rdata
	always_ff @(posedge clk) begin
		if (cs) begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr]; // registered read, data after the edge
		end
	end

	// a selected access must carry a clean address or the macro
	// would corrupt an unknown row
	a_addr_known: assert property (
		@(posedge clk) cs |-> !$isunknown(addr)
	) else $error("icache data ram accessed with unknown address");

	// only the plain and the SECDED word widths exist as macros
	a_width_legal: assert property (
		@(posedge clk) (DW == 64) || (DW == 72)
	) else $error("icache data ram width %0d is not 64 or 72", DW);

endmodule

// ==== rtl/ecc_secded_enc.sv ====
// combinational (72,64) extended hamming encoder for the icache data array write path
`timescale 1ns/1ps

module ecc_secded_enc (
	input  logic [63:0]         data,
	output ecc_pkg::ecc_check_t check
);

	logic [6:0] contrib [64];
	logic [6:0] hamming;

	// each set data bit contributes its position to the check bits
	for (genvar i = 0; i < 64; i++) begin : g_contrib
		localparam logic [6:0] POS = ecc_pkg::data_pos(i);
		assign contrib[i] = data[i] ? POS : 7'd0;
	end

	always_comb begin
		hamming = '0;
		for (int i = 0; i < 64; i++)
			hamming ^= contrib[i]; // ci collects bits with position bit i set
	end

	// overall parity covers data and the seven hamming checks
	assign check.hamming = hamming;
	assign check.parity  = ^{data, hamming};

endmodule

// ==== rtl/ecc_secded_dec.sv ====
// combinational SECDED decoder that corrects single and flags double errors on icache reads
`timescale 1ns/1ps

module ecc_secded_dec (
	input  logic                   clk, // samples the assertion only
	input  ecc_pkg::ecc_codeword_t codeword,
	output logic [63:0]            data,
	output ecc_pkg::ecc_status_t   status
);

	logic [6:0]  contrib [64];
	logic [6:0]  recomputed;
	logic [6:0]  syndrome;
	logic [63:0] hit;
	logic        parity_err;

	for (genvar i = 0; i < 64; i++) begin : g_bit
		localparam logic [6:0] POS = ecc_pkg::data_pos(i);
		assign contrib[i] = codeword.data[i] ? POS : 7'd0;
		assign hit[i]     = (syndrome == POS); // syndrome points at this data bit
	end

	always_comb begin
		recomputed = '0;
		for (int i = 0; i < 64; i++)
			recomputed ^= contrib[i];
	end

	assign syndrome   = recomputed ^ codeword.check.hamming;
	assign parity_err = ^codeword; // odd number of flips anywhere in the word

	always_comb begin
		status = '0;
		data   = codeword.data;
		if (parity_err) begin
			if (syndrome > 7'd71) begin
				// no such position, so at least three bits flipped
				status.double_err = 1'b1;
			end else begin
				status.single_err = 1'b1;
				data = codeword.data ^ hit; // hit is zero for a check or parity flip
			end
		end else if (syndrome != 7'd0) begin
			status.double_err = 1'b1;
		end
	end

	a_flags_exclusive: assert property (
		@(posedge clk) !(status.single_err && status.double_err)
	) else $error("ecc decoder raised single and double error together");

endmodule

// ==== rtl/icache_data_array.sv ====
// icache data array top level that encodes writes, stores them and returns checked read data
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_data_array (
	input  logic                         clk,
	input  logic                         reset,
	input  icache_pkg::icache_data_req_t req,
	output icache_pkg::icache_data_rsp_t rsp
);

	localparam int AW     = `ICACHE_DATA_RAM_AW;
	localparam int RAM_DW = (`ICACHE_ECC_EN != 0) ? $bits(ecc_pkg::ecc_codeword_t)
		: `ICACHE_DATA_DW;

	logic [RAM_DW-1:0]          ram_wdata;
	logic [RAM_DW-1:0]          ram_rdata;
	logic                       rsp_valid;
	logic [`ICACHE_DATA_DW-1:0] rsp_rdata;
	ecc_pkg::ecc_status_t       rsp_status;

	if (`ICACHE_ECC_EN != 0) begin : g_ecc
		ecc_pkg::ecc_check_t    wr_check;
		ecc_pkg::ecc_codeword_t wr_word;

		ecc_secded_enc i_enc (
			.data  (req.wdata),
			.check (wr_check)
		);

		// inject flips bits after encoding so the decoder sees a real fault
		assign wr_word   = {wr_check, req.wdata} ^ req.inject;
		assign ram_wdata = wr_word;

		ecc_secded_dec i_dec (
			.clk      (clk),
			.codeword (ram_rdata),
			.data     (rsp_rdata),
			.status   (rsp_status)
		);
	end else begin : g_raw
		assign ram_wdata  = req.wdata;
		assign rsp_rdata  = ram_rdata;
		assign rsp_status = '0;
	end

	icache_data_ecc_ram #(
		.AW (AW),
		.DW (RAM_DW)
	) i_ram (
		.clk   (clk),
		.cs    (req.cs),
		.we    (req.we),
		.addr  (req.addr),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	// read data leaves the RAM one cycle after the request, valid follows it
	always_ff @(posedge clk) begin
		if (reset)
			rsp_valid <= 1'b0;
		else
			rsp_valid <= req.cs & ~req.we;
	end

	assign rsp = '{valid: rsp_valid, rdata: rsp_rdata, status: rsp_status};

endmodule

// ==== bench/icache_data_array_tb.sv ====
// self-checking testbench for the icache data array, run from src.f with the top icache_data_array_tb
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_data_array_tb;

	localparam int AW = `ICACHE_DATA_RAM_AW;
	localparam int NUM_RANDOM = 400;
	// reset, four directed tests of 16 operations, the random run and a few drain cycles per test
	localparam int TOTAL_OPS = 8 + 4 * 16 + NUM_RANDOM + 5 * 4;
	localparam int unsigned TIMEOUT_CYCLES = 4 * TOTAL_OPS + 200;

	typedef struct packed {
		logic [31:0]          due;
		logic [63:0]          rdata;
		ecc_pkg::ecc_status_t status;
	} exp_rsp_t;

	logic                         clk = 1'b0;
	logic                         reset;
	icache_pkg::icache_data_req_t req;
	icache_pkg::icache_data_rsp_t rsp;

	logic [31:0] lfsr_state = 32'h9774_6ad3;
	int unsigned cycle = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	exp_rsp_t    exp_q [$];
	logic [71:0] shadow [int]; // codeword as stored, inject included

	icache_data_array i_dut (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.rsp   (rsp)
	);

	always #5 clk = ~clk;

	function automatic logic lfsr_step();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[62:0], lfsr_step()};
		return r;
	endfunction

	function automatic int rand_pos72();
		return int'(rand_bits(7) % 64'd72);
	endfunction

	// flip mask with nflips distinct random bits over the whole codeword
	function automatic logic [71:0] flip_mask(input int nflips);
		int          p1;
		int          p2;
		logic [71:0] m;
		m = '0;
		p1 = 0;
		if (nflips >= 1) begin
			p1 = rand_pos72();
			m[p1] = 1'b1;
		end
		if (nflips >= 2) begin
			p2 = p1;
			while (p2 == p1)
				p2 = rand_pos72();
			m[p2] = 1'b1;
		end
		return m;
	endfunction

	// data bit idx sits at the idx-th position that is not a power of two, counting from 3
	function automatic logic [6:0] hamming_pos(input int idx);
		int pos;
		pos = 2;
		for (int k = 0; k <= idx; k++) begin
			pos++;
			while ((pos & (pos - 1)) == 0)
				pos++;
		end
		return pos[6:0];
	endfunction

	function automatic logic [6:0] hamming_of(input logic [63:0] data);
		logic [6:0] h;
		h = '0;
		for (int i = 0; i < 64; i++) begin
			if (data[i])
				h = h ^ hamming_pos(i);
		end
		return h;
	endfunction

	function automatic logic [71:0] ref_encode(input logic [63:0] data);
		logic [6:0] h;
		logic       parity;
		h = hamming_of(data);
		parity = (^data) ^ (^h);
		return {h, parity, data};
	endfunction

	function automatic void ref_decode(input logic [71:0] cw, output logic [63:0] data,
		output ecc_pkg::ecc_status_t status);
		logic [6:0] syn;
		logic       perr;
		data = cw[63:0];
		syn = hamming_of(cw[63:0]) ^ cw[71:65];
		perr = ^cw;
		status = '0;
		if (perr) begin
			if (syn > 7'd71) begin
				status.double_err = 1'b1;
			end else begin
				status.single_err = 1'b1;
				for (int i = 0; i < 64; i++) begin
					if (hamming_pos(i) == syn)
						data[i] = ~data[i];
				end
			end
		end else if (syn != 7'd0) begin
			status.double_err = 1'b1;
		end
	endfunction

	// comparison happens on the rising edge, before the DUT registers move
	always @(posedge clk) begin : compare
		exp_rsp_t e;
		cycle = cycle + 1;
		if (!reset) begin
			checks++;
			if (exp_q.size() != 0 && exp_q[0].due == cycle) begin
				e = exp_q.pop_front();
				if (rsp.valid !== 1'b1) begin
					errors++;
					$display("mismatch valid at cycle %0d: got %h expected 1", cycle, rsp.valid);
				end
				if (rsp.rdata !== e.rdata) begin
					errors++;
					$display("mismatch rdata at cycle %0d: got %h expected %h",
						cycle, rsp.rdata, e.rdata);
				end
				if (rsp.status !== e.status) begin
					errors++;
					$display("mismatch status at cycle %0d: got %h expected %h",
						cycle, rsp.status, e.status);
				end
			end else begin
				if (rsp.valid !== 1'b0) begin
					errors++;
					$display("mismatch valid at cycle %0d: got %h expected 0", cycle, rsp.valid);
				end
			end
		end
	end

	initial begin
		wait (cycle >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	task automatic idle_cycles(input int n);
		req.cs = 1'b0;
		req.we = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic do_write(input logic [AW-1:0] addr, input logic [63:0] data,
		input logic [71:0] inj);
		req.cs = 1'b1;
		req.we = 1'b1;
		req.addr = addr;
		req.wdata = data;
		req.inject = inj;
		if (`ICACHE_ECC_EN != 0)
			shadow[int'(addr)] = ref_encode(data) ^ inj;
		else
			shadow[int'(addr)] = {8'h00, data}; // raw store ignores the mask
		@(negedge clk);
	endtask

	task automatic do_read(input logic [AW-1:0] addr);
		exp_rsp_t e;
		req.cs = 1'b1;
		req.we = 1'b0;
		req.addr = addr;
		req.wdata = '0;
		req.inject = '0;
		e.due = cycle + 2; // sampled on the next edge, checked on the one after
		if (`ICACHE_ECC_EN != 0) begin
			ref_decode(shadow[int'(addr)], e.rdata, e.status);
		end else begin
			e.rdata = shadow[int'(addr)][63:0];
			e.status = '0;
		end
		exp_q.push_back(e);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input int err_before);
		req.cs = 1'b0;
		req.we = 1'b0;
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
	endtask

	task automatic test_clean();
		int err_before;
		err_before = errors;
		idle_cycles(4);
		for (int i = 0; i < 6; i++)
			do_write(AW'(i * 41 + 3), rand_bits(64), '0);
		for (int i = 0; i < 6; i++)
			do_read(AW'(i * 41 + 3));
		finish_test("clean write and read", err_before);
	endtask

	task automatic test_single_data();
		int            err_before;
		logic [63:0]   r;
		logic [AW-1:0] addr;
		err_before = errors;
		for (int i = 0; i < 8; i++) begin
			r = rand_bits(AW);
			addr = r[AW-1:0];
			do_write(addr, rand_bits(64), 72'd1 << int'(rand_bits(6)));
			do_read(addr);
		end
		finish_test("single data bit flip", err_before);
	endtask

	task automatic test_single_check();
		int          err_before;
		logic [71:0] mask;
		err_before = errors;
		for (int i = 0; i < 8; i++) begin
			mask = 72'd1 << (64 + i); // i = 0 hits the overall parity, the rest c0 to c6
			do_write(AW'(i + 200), rand_bits(64), mask);
			do_read(AW'(i + 200));
		end
		finish_test("single check bit flip", err_before);
	endtask

	task automatic test_double();
		int            err_before;
		logic [63:0]   r;
		logic [AW-1:0] addr;
		err_before = errors;
		for (int i = 0; i < 8; i++) begin
			r = rand_bits(AW);
			addr = r[AW-1:0];
			do_write(addr, rand_bits(64), flip_mask(2));
			do_read(addr);
		end
		finish_test("double bit flip", err_before);
	endtask

	task automatic test_random();
		int            err_before;
		int            nflips;
		logic          is_write;
		logic          force_read;
		logic [63:0]   r;
		logic [AW-1:0] addr;
		logic [AW-1:0] last_addr;
		err_before = errors;
		force_read = 1'b0;
		last_addr = '0;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			if (force_read) begin
				do_read(last_addr); // same address, the cycle after its write
				force_read = 1'b0;
			end else begin
				is_write = rand_bits(1) != 64'd0;
				r = rand_bits(AW);
				addr = r[AW-1:0];
				if (!is_write && !shadow.exists(int'(addr)))
					is_write = 1'b1;
				if (is_write) begin
					nflips = int'(rand_bits(2));
					if (nflips == 3)
						nflips = 0;
					do_write(addr, rand_bits(64), flip_mask(nflips));
					last_addr = addr;
					force_read = rand_bits(1) != 64'd0;
				end else begin
					do_read(addr);
				end
			end
		end
		finish_test("random back to back traffic", err_before);
	endtask

	initial begin
		req = '0;
		reset = 1'b1;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		test_clean();
		test_single_data();
		test_single_check();
		test_double();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/ecc_pkg.sv
rtl/icache_pkg.sv
rtl/icache_data_ecc_ram.sv
rtl/ecc_secded_enc.sv
rtl/ecc_secded_dec.sv
rtl/icache_data_array.sv
bench/icache_data_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it, the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module icache_data_array_tb \
	-o icache_data_array_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/icache_data_array_sim > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
